// File: entry_store.sv
`timescale 1ns/1ps

module entry_store #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Reads are combinational, the reader registers the result
    assign rdata = mem[raddr];

    waddr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        we |-> waddr < depth
    );

endmodule

// File: line_fetcher.sv
`timescale 1ns/1ps
`include "ppu_cfg.svh"

module line_fetcher import tile_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    video_timing_if.fetch timing,
    output map_addr_t     tile_map_addr,
    input  logic [31:0]   tile_map_data,
    output gfx_addr_t     tile_gfx_addr,
    input  logic [31:0]   tile_gfx_data,
    input  tile_slot_t    raddr,
    output line_entry_t   rdata
);

    localparam int FINAL_STEP = `PPU_FETCH_STEPS;

    logic [5:0]  step;
    logic [5:0]  tile_row;
    logic [3:0]  tile_line;
    logic        map_phase;
    logic        id_phase;
    logic [1:0]  byte_sel;
    logic [7:0]  map_byte;
    tile_id_t    tile_id;
    map_addr_t   map_word;
    gfx_addr_t   gfx_word;
    logic        pal_sel_q;
    logic        we;
    tile_slot_t  waddr;
    line_entry_t wdata;

    assign tile_row  = 6'(timing.vcount / `PPU_TILE_HEIGHT);
    assign tile_line = 4'(timing.vcount % `PPU_TILE_HEIGHT);

    // Stage 1 sends map addresses, four tiles share one word
    assign map_phase = step < `PPU_TILES_PER_LINE;
    assign map_word  = map_addr_t'(tile_row) * map_addr_t'(`PPU_MAP_WORDS_PER_ROW)
                     + map_addr_t'(step[5:2]);

    // Stage 2 picks the byte of the tile sent one step earlier
    assign id_phase = step >= 1 && step <= `PPU_TILES_PER_LINE;
    assign byte_sel = 2'(step - 6'd1);
    assign map_byte = tile_map_data[8*byte_sel +: 8];
    assign tile_id  = map_byte[6:0];
    assign gfx_word = gfx_addr_t'(tile_id) * gfx_addr_t'(`PPU_TILE_HEIGHT)
                    + gfx_addr_t'(tile_line);

    // Stage 3 stores the graphics row of the tile two steps back
    assign we    = timing.hsync && step >= 2 && step < FINAL_STEP;
    assign waddr = tile_slot_t'(step - 6'd2);
    assign wdata = '{gfx: tile_gfx_data, pal_sel: pal_sel_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            step          <= '0;
            tile_map_addr <= '0;
            tile_gfx_addr <= '0;
        end else if (!timing.hsync) begin
            step          <= '0;
            tile_map_addr <= '0;
            tile_gfx_addr <= '0;
        end else begin
            if (step < FINAL_STEP) begin
                step <= step + 6'd1;     // Parks at the final value
            end
            tile_map_addr <= map_phase ? map_word : '0;
            tile_gfx_addr <= id_phase ? gfx_word : '0;
        end
    end

    // Palette select travels alongside its graphics request
    always_ff @(posedge clk) begin
        if (id_phase) begin
            pal_sel_q <= map_byte[7];
        end
    end

    entry_store #(
        .entry_t (line_entry_t),
        .depth   (`PPU_TILES_PER_LINE)
    ) line_store (
        .clk   (clk),
        .reset (reset),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

    // Hsync has to stay high until every step of the line fetch has run
    fetch_completes: assert property (
        @(posedge clk) disable iff (reset)
        $fell(timing.hsync) |-> step == FINAL_STEP
    );

endmodule

// File: list.f
+incdir+.
video_pkg.sv
tile_pkg.sv
video_timing_if.sv
entry_store.sv
palette_loader.sv
line_fetcher.sv
pixel_generator.sv
ppu_top.sv
tb_ppu.sv

// File: palette_loader.sv
`timescale 1ns/1ps
`include "ppu_cfg.svh"

module palette_loader import tile_pkg::*, video_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    video_timing_if.load timing,
    output palette_idx_t palette_addr,
    input  rgb_t         palette_data,
    input  palette_idx_t raddr,
    output rgb_t         rdata
);

    localparam int LAST_STEP = `PPU_PALETTE_ENTRIES + 1;

    logic [3:0]   step;
    logic         we;
    palette_idx_t waddr;

    // Data for the address driven one step earlier
    assign we    = timing.vblank && step >= 1 && step <= `PPU_PALETTE_ENTRIES;
    assign waddr = palette_idx_t'(step - 4'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            step         <= '0;
            palette_addr <= '0;
        end else if (!timing.vblank) begin
            step         <= '0;     // Rearm for the next frame
            palette_addr <= '0;
        end else begin
            if (step < LAST_STEP) begin
                step <= step + 4'd1;
            end
            palette_addr <= (step < `PPU_PALETTE_ENTRIES) ? palette_idx_t'(step) : '0;
        end
    end

    entry_store #(
        .entry_t (rgb_t),
        .depth   (`PPU_PALETTE_ENTRIES)
    ) palette_cache (
        .clk   (clk),
        .reset (reset),
        .we    (we),
        .waddr (waddr),
        .wdata (palette_data),
        .raddr (raddr),
        .rdata (rdata)
    );

    // Each color lands in the entry whose address went out a cycle earlier
    write_follows_addr: assert property (
        @(posedge clk) disable iff (reset)
        we |-> waddr == palette_addr
    );

endmodule

// File: pixel_generator.sv
`timescale 1ns/1ps
`include "ppu_cfg.svh"

module pixel_generator import tile_pkg::*, video_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    video_timing_if.pixel timing,
    output tile_slot_t    line_raddr,
    input  line_entry_t   line_rdata,
    output palette_idx_t  pal_raddr,
    input  rgb_t          pal_rdata,
    output rgb_t          pixel_color
);

    tile_slot_t slot;
    logic [3:0] pix;
    logic [1:0] pix_bits;
    logic       active;

    // A doubled tile spans 32 counts
    assign slot = timing.hcount[10:5];
    assign pix  = timing.hcount[4:1];     // Each pixel shown for two counts

    assign line_raddr = slot;
    assign pix_bits   = line_rdata.gfx[31 - 2*pix -: 2];   // Leftmost pixel in the top bits

    // Upper half of the palette when the tile selects it
    assign pal_raddr = {line_rdata.pal_sel, pix_bits};

    assign active = !timing.vblank && !timing.hsync;

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (active) begin
            // Right of the last tile shows black
            pixel_color <= (slot < `PPU_TILES_PER_LINE) ? pal_rdata : '0;
        end
    end

endmodule

// File: ppu_cfg.svh
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Background geometry
`define PPU_TILES_PER_LINE 40     // 640 pixels of 16-pixel tiles
`define PPU_TILE_HEIGHT 16        // Rows in one tile

// Palette cache size
`define PPU_PALETTE_ENTRIES 8     // Two palettes of four colors

// Tile-map layout, four tile ids per 32-bit word
`define PPU_MAP_WORDS_PER_ROW 10

// Hsync cycles one line fetch occupies
`define PPU_FETCH_STEPS 42

`endif

// File: ppu_top.sv
`timescale 1ns/1ps

module ppu_top import tile_pkg::*, video_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  hcount_t      hcount,
    input  vcount_t      vcount,
    input  logic         vblank,
    input  logic         hsync,
    output rgb_t         pixel_color,

    // Palette memory
    output palette_idx_t palette_addr,
    input  rgb_t         palette_data,

    // Tile map and tile graphics memories
    output map_addr_t    tile_map_addr,
    input  logic [31:0]  tile_map_data,
    output gfx_addr_t    tile_gfx_addr,
    input  logic [31:0]  tile_gfx_data
);

    tile_slot_t   line_raddr;
    line_entry_t  line_rdata;
    palette_idx_t pal_raddr;
    rgb_t         pal_rdata;

    video_timing_if timing_if ();

    assign timing_if.hcount = hcount;
    assign timing_if.vcount = vcount;
    assign timing_if.vblank = vblank;
    assign timing_if.hsync  = hsync;

    palette_loader palette_loader_i (
        .clk          (clk),
        .reset        (reset),
        .timing       (timing_if.load),
        .palette_addr (palette_addr),
        .palette_data (palette_data),
        .raddr        (pal_raddr),
        .rdata        (pal_rdata)
    );

    line_fetcher line_fetcher_i (
        .clk           (clk),
        .reset         (reset),
        .timing        (timing_if.fetch),
        .tile_map_addr (tile_map_addr),
        .tile_map_data (tile_map_data),
        .tile_gfx_addr (tile_gfx_addr),
        .tile_gfx_data (tile_gfx_data),
        .raddr         (line_raddr),
        .rdata         (line_rdata)
    );

    pixel_generator pixel_generator_i (
        .clk         (clk),
        .reset       (reset),
        .timing      (timing_if.pixel),
        .line_raddr  (line_raddr),
        .line_rdata  (line_rdata),
        .pal_raddr   (pal_raddr),
        .pal_rdata   (pal_rdata),
        .pixel_color (pixel_color)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the PPU testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu -f list.f \
    && { ./obj_dir/Vtb_ppu > sim.log 2>&1; cat sim.log; } \
    && grep -q "ALL CHECKS PASSED" sim.log \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_ppu.sv
`timescale 1ns/1ps
`include "ppu_cfg.svh"

module tb_ppu import tile_pkg::*, video_pkg::*;;

    localparam int FRAMES        = 2;
    localparam int VBLANK_CYCLES = 12;
    localparam int LINES         = 3;
    localparam int HSYNC_CYCLES  = 48;
    localparam int ACTIVE_CYCLES = 200;
    localparam int CLK_PERIOD    = 10;
    localparam int TIMEOUT_NS    =
        2 * FRAMES * (VBLANK_CYCLES + LINES * (HSYNC_CYCLES + ACTIVE_CYCLES)) * CLK_PERIOD;

    logic         clk;
    logic         reset;
    hcount_t      hcount;
    vcount_t      vcount;
    logic         vblank;
    logic         hsync;
    rgb_t         pixel_color;
    palette_idx_t palette_addr;
    rgb_t         palette_data;
    map_addr_t    tile_map_addr;
    logic [31:0]  tile_map_data;
    gfx_addr_t    tile_gfx_addr;
    logic [31:0]  tile_gfx_data;

    // External memory contents
    rgb_t        pal_mem [`PPU_PALETTE_ENTRIES];
    logic [31:0] map_mem [512];
    logic [31:0] gfx_mem [2048];

    // Reference copies of the palette cache and line store
    rgb_t        pal_model [`PPU_PALETTE_ENTRIES];
    logic [31:0] line_gfx  [`PPU_TILES_PER_LINE];
    logic        line_sel  [`PPU_TILES_PER_LINE];

    integer seed;
    int     color_errors;
    int     pal_addr_errors;
    int     map_addr_errors;
    int     gfx_addr_errors;
    rgb_t   last_color;     // Color the DUT should be holding

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ppu_top ppu_top_i (
        .clk           (clk),
        .reset         (reset),
        .hcount        (hcount),
        .vcount        (vcount),
        .vblank        (vblank),
        .hsync         (hsync),
        .pixel_color   (pixel_color),
        .palette_addr  (palette_addr),
        .palette_data  (palette_data),
        .tile_map_addr (tile_map_addr),
        .tile_map_data (tile_map_data),
        .tile_gfx_addr (tile_gfx_addr),
        .tile_gfx_data (tile_gfx_data)
    );

    task automatic fill_memories();
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            pal_mem[i] = rgb_t'($random(seed));
        end
        for (int i = 0; i < 512; i++) begin
            map_mem[i] = $random(seed);
        end
        for (int i = 0; i < 2048; i++) begin
            gfx_mem[i] = $random(seed);
        end
    endtask

    // Answer the addresses registered at the last rising edge
    task automatic serve_memories();
        palette_data  = pal_mem[palette_addr];
        tile_map_data = map_mem[tile_map_addr];
        tile_gfx_data = gfx_mem[tile_gfx_addr];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        serve_memories();
    endtask

    task automatic check_color(input rgb_t actual, input rgb_t expected);
        if (actual !== expected) begin
            color_errors++;
            $display("error: pixel_color expected %h got %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_palette_addr(input palette_idx_t actual, input palette_idx_t expected);
        if (actual !== expected) begin
            pal_addr_errors++;
            $display("error: palette_addr expected %h got %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_map_addr(input map_addr_t actual, input map_addr_t expected);
        if (actual !== expected) begin
            map_addr_errors++;
            $display("error: tile_map_addr expected %h got %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_gfx_addr(input gfx_addr_t actual, input gfx_addr_t expected);
        if (actual !== expected) begin
            gfx_addr_errors++;
            $display("error: tile_gfx_addr expected %h got %h at %0t", expected, actual, $time);
        end
    endtask

    // Map byte of tile t in the row that holds scan line v
    function automatic logic [7:0] tile_byte(input vcount_t v, input int t);
        logic [31:0] word;
        word = map_mem[(v / `PPU_TILE_HEIGHT) * `PPU_MAP_WORDS_PER_ROW + t / 4];
        return word[8 * (t % 4) +: 8];
    endfunction

    function automatic gfx_addr_t gfx_address(input vcount_t v, input int t);
        logic [7:0] b;
        b = tile_byte(v, t);
        return gfx_addr_t'(int'(b[6:0]) * `PPU_TILE_HEIGHT + int'(v % `PPU_TILE_HEIGHT));
    endfunction

    function automatic rgb_t expected_color(input hcount_t h);
        int         slot;
        int         p;
        logic [1:0] bits;
        slot = h / 32;
        if (slot >= `PPU_TILES_PER_LINE) begin
            return '0;     // Past the last tile
        end
        p    = (h / 2) % 16;
        bits = 2'(line_gfx[slot] >> (30 - 2 * p));
        return pal_model[int'(line_sel[slot]) * 4 + int'(bits)];
    endfunction

    task automatic run_vblank();
        vblank = 1'b1;
        for (int n = 0; n < VBLANK_CYCLES; n++) begin
            next_cycle();
            check_palette_addr(palette_addr, palette_idx_t'(n < `PPU_PALETTE_ENTRIES ? n : 0));
            check_map_addr(tile_map_addr, map_addr_t'(0));
            check_gfx_addr(tile_gfx_addr, gfx_addr_t'(0));
            check_color(pixel_color, last_color);
        end
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            pal_model[i] = pal_mem[i];
        end
        vblank = 1'b0;
    endtask

    task automatic run_hsync();
        vcount_t    v;
        logic [7:0] b;
        v      = vcount_t'({$random(seed)} % 480);
        vcount = v;
        hsync  = 1'b1;
        for (int e = 0; e < HSYNC_CYCLES; e++) begin
            next_cycle();
            check_map_addr(tile_map_addr, e < `PPU_TILES_PER_LINE ?
                map_addr_t'((v / `PPU_TILE_HEIGHT) * `PPU_MAP_WORDS_PER_ROW + e / 4) :
                map_addr_t'(0));
            check_gfx_addr(tile_gfx_addr, (e >= 1 && e <= `PPU_TILES_PER_LINE) ?
                gfx_address(v, e - 1) : gfx_addr_t'(0));
            check_palette_addr(palette_addr, palette_idx_t'(0));
            check_color(pixel_color, last_color);     // Held through hsync
        end
        for (int t = 0; t < `PPU_TILES_PER_LINE; t++) begin
            b           = tile_byte(v, t);
            line_gfx[t] = gfx_mem[gfx_address(v, t)];
            line_sel[t] = b[7];
        end
        hsync = 1'b0;
    endtask

    task automatic run_active();
        hcount_t h;
        for (int i = 0; i < ACTIVE_CYCLES; i++) begin
            h      = hcount_t'({$random(seed)} % 1400);     // Some beyond 1279
            hcount = h;
            next_cycle();
            last_color = expected_color(h);
            check_color(pixel_color, last_color);
        end
    endtask

    initial begin
        seed          = 32'h55c5;
        reset         = 1'b1;
        hcount        = '0;
        vcount        = '0;
        vblank        = 1'b0;
        hsync         = 1'b0;
        palette_data  = '0;
        tile_map_data = '0;
        tile_gfx_data = '0;
        last_color    = '0;
        color_errors    = 0;
        pal_addr_errors = 0;
        map_addr_errors = 0;
        gfx_addr_errors = 0;
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            pal_model[i] = '0;
        end
        for (int t = 0; t < `PPU_TILES_PER_LINE; t++) begin
            line_gfx[t] = '0;
            line_sel[t] = 1'b0;
        end
        fill_memories();

        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Idle after reset, everything still cleared
        repeat (4) begin
            next_cycle();
            check_color(pixel_color, rgb_t'(0));
            check_palette_addr(palette_addr, palette_idx_t'(0));
            check_map_addr(tile_map_addr, map_addr_t'(0));
            check_gfx_addr(tile_gfx_addr, gfx_addr_t'(0));
        end

        for (int f = 0; f < FRAMES; f++) begin
            if (f > 0) begin
                fill_memories();     // New contents must show up after reload
            end
            run_vblank();
            for (int l = 0; l < LINES; l++) begin
                run_hsync();
                run_active();
            end
        end

        $display("errors: pixel_color %0d, palette_addr %0d, tile_map_addr %0d, tile_gfx_addr %0d",
                 color_errors, pal_addr_errors, map_addr_errors, gfx_addr_errors);
        if (color_errors + pal_addr_errors + map_addr_errors + gfx_addr_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: tile_pkg.sv
package tile_pkg;

    typedef logic [2:0] palette_idx_t;   // Palette cache and palette memory address

    typedef logic [8:0]  map_addr_t;     // Tile-map word address
    typedef logic [10:0] gfx_addr_t;     // Tile graphics row address

    typedef logic [6:0] tile_id_t;
    typedef logic [5:0] tile_slot_t;     // Tile position within a scan line

    // One tile of the current scan line
    typedef struct packed {
        logic [31:0] gfx;                // 16 pixels, pixel 0 in the top bits
        logic        pal_sel;            // Selects the upper four palette colors
    } line_entry_t;

endpackage

// File: video_pkg.sv
package video_pkg;

    // Counts from the VGA controller
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // 8 bits each of red, green, blue
    typedef logic [23:0] rgb_t;

endpackage

// File: video_timing_if.sv
`timescale 1ns/1ps

interface video_timing_if import video_pkg::*; ();

    hcount_t hcount;
    vcount_t vcount;
    logic    vblank;
    logic    hsync;

    // Line fetch only needs the row and the fetch window
    modport fetch (
        input vcount,
        input hsync
    );

    modport load (
        input vblank
    );

    // Pixel output runs only outside both blanking windows
    modport pixel (
        input hcount,
        input vblank,
        input hsync
    );

endinterface
